// ==== filelist.f ====
hdl/imuldiv_pkg.sv
hdl/imuldiv_int_div_dpath.sv
hdl/imuldiv_int_div_ctrl.sv
hdl/imuldiv_int_div_iterative.sv
hdl/imuldiv_int_mul_iterative.sv
hdl/imuldiv_muldiv_unit.sv
verification/imuldiv_assertions.sv
verification/imuldiv_tb.sv

// ==== hdl/imuldiv_int_div_ctrl.sv ====
//--------------------
// divider control
// idle/calc/done FSM driving the datapath enables and selects
//--------------------

`timescale 1ns/100ps
`default_nettype none

module imuldiv_int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic sub_out64,
  input  logic counter_is_zero,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic sub_mux_sel,
  output logic cntr_mux_sel,
  output logic sign_en,
  output logic div_sign_mux_sel,
  output logic rem_sign_mux_sel
);

  imuldiv_pkg::iter_state_t state;
  imuldiv_pkg::iter_state_t state_next;

  // request handshake only possible in idle
  logic req_go;

  assign req_go = (state == imuldiv_pkg::ST_IDLE) && req_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::ST_IDLE: if (req_val) state_next = imuldiv_pkg::ST_CALC;
      // last iteration runs while counter reads zero
      imuldiv_pkg::ST_CALC: if (counter_is_zero) state_next = imuldiv_pkg::ST_DONE;
      imuldiv_pkg::ST_DONE: if (resp_rdy) state_next = imuldiv_pkg::ST_IDLE;
      default:              state_next = imuldiv_pkg::ST_IDLE;
    endcase
  end

  //--------------------
  // datapath controls
  //--------------------

  assign req_rdy  = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val = (state == imuldiv_pkg::ST_DONE);

  // load operands and signs on the handshake, then iterate
  assign a_en         = req_go || (state == imuldiv_pkg::ST_CALC);
  assign b_en         = req_go;
  assign sign_en      = req_go;
  assign a_mux_sel    = (state == imuldiv_pkg::ST_CALC);
  assign sub_mux_sel  = (state == imuldiv_pkg::ST_CALC) && sub_out64;
  assign cntr_mux_sel = (state == imuldiv_pkg::ST_CALC);

  // result is corrected only when presented
  assign div_sign_mux_sel = resp_val;
  assign rem_sign_mux_sel = resp_val;

endmodule

`default_nettype wire

// ==== hdl/imuldiv_int_div_dpath.sv ====
//--------------------
// divider datapath
// restoring shift-subtract on operand magnitudes, sign fixup at output
//--------------------

`timescale 1ns/100ps
`default_nettype none

module imuldiv_int_div_dpath (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             is_signed,
  input  logic [imuldiv_pkg::DATA_W-1:0]   req_a,
  input  logic [imuldiv_pkg::DATA_W-1:0]   req_b,
  // controls from the FSM
  input  logic                             a_en,
  input  logic                             b_en,
  input  logic                             a_mux_sel,
  input  logic                             sub_mux_sel,
  input  logic                             cntr_mux_sel,
  input  logic                             sign_en,
  input  logic                             div_sign_mux_sel,
  input  logic                             rem_sign_mux_sel,
  // status back to the FSM
  output logic                             sub_out64,
  output logic                             counter_is_zero,
  output logic [imuldiv_pkg::RESULT_W-1:0] resp_result
);

  localparam int W = imuldiv_pkg::DATA_W;

  // {spare, remainder, quotient} and shifted divisor
  logic [2*W:0] a_reg;
  logic [2*W:0] b_reg;
  logic [imuldiv_pkg::CNT_W-1:0] counter_reg;
  logic quot_sign_reg;
  logic rem_sign_reg;

  //--------------------
  // operand normalization
  //--------------------

  logic [W-1:0] a_norm;
  logic [W-1:0] b_norm;

  // take magnitudes only for signed ops
  assign a_norm = (is_signed && req_a[W-1]) ? -req_a : req_a;
  assign b_norm = (is_signed && req_b[W-1]) ? -req_b : req_b;

  //--------------------
  // shift and subtract
  //--------------------

  logic [2*W:0] a_shift;
  logic [2*W:0] sub_out;
  logic [2*W:0] sub_mux_out;
  logic [2*W:0] a_mux_out;

  assign a_shift = a_reg << 1;
  assign sub_out = a_shift - b_reg;
  // msb set means divisor did not fit
  assign sub_out64 = sub_out[2*W];

  // restore keeps the shifted value with quotient bit 0
  assign sub_mux_out = sub_mux_sel ? {a_shift[2*W:1], 1'b0} : {sub_out[2*W:1], 1'b1};
  assign a_mux_out   = a_mux_sel ? sub_mux_out : {{(W+1){1'b0}}, a_norm};

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= {1'b0, b_norm, {W{1'b0}}};
    end
    if (sign_en) begin
      // quotient negative on differing signs, remainder follows dividend
      quot_sign_reg <= is_signed && (req_a[W-1] ^ req_b[W-1]);
      rem_sign_reg  <= is_signed && req_a[W-1];
    end
  end

  //--------------------
  // iteration counter
  //--------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= '0;
    end else if (cntr_mux_sel) begin
      counter_reg <= counter_reg - 1'b1;
    end else begin
      counter_reg <= imuldiv_pkg::CNT_W'(imuldiv_pkg::ITER_COUNT - 1);
    end
  end

  assign counter_is_zero = (counter_reg == '0);

  // sign correction, applied once the FSM reaches done
  logic [W-1:0] quotient;
  logic [W-1:0] remainder;

  assign quotient  = a_reg[W-1:0];
  assign remainder = a_reg[2*W-1:W];

  assign resp_result[W-1:0]   = (div_sign_mux_sel && quot_sign_reg) ? -quotient : quotient;
  assign resp_result[2*W-1:W] = (rem_sign_mux_sel && rem_sign_reg) ? -remainder : remainder;

endmodule

`default_nettype wire

// ==== hdl/imuldiv_int_div_iterative.sv ====
//--------------------
// iterative divider engine
// joins the divider datapath and its control FSM
//--------------------

`timescale 1ns/100ps
`default_nettype none

module imuldiv_int_div_iterative (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             is_signed,
  input  logic [imuldiv_pkg::DATA_W-1:0]   req_a,
  input  logic [imuldiv_pkg::DATA_W-1:0]   req_b,
  input  logic                             req_val,
  output logic                             req_rdy,
  output logic [imuldiv_pkg::RESULT_W-1:0] resp_result,
  output logic                             resp_val,
  input  logic                             resp_rdy
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;
  logic div_sign_mux_sel;
  logic rem_sign_mux_sel;
  // datapath status
  logic sub_out64;
  logic counter_is_zero;

  imuldiv_int_div_dpath u_dpath (
    .clk              (clk),
    .reset            (reset),
    .is_signed        (is_signed),
    .req_a            (req_a),
    .req_b            (req_b),
    .a_en             (a_en),
    .b_en             (b_en),
    .a_mux_sel        (a_mux_sel),
    .sub_mux_sel      (sub_mux_sel),
    .cntr_mux_sel     (cntr_mux_sel),
    .sign_en          (sign_en),
    .div_sign_mux_sel (div_sign_mux_sel),
    .rem_sign_mux_sel (rem_sign_mux_sel),
    .sub_out64        (sub_out64),
    .counter_is_zero  (counter_is_zero),
    .resp_result      (resp_result)
  );

  imuldiv_int_div_ctrl u_ctrl (
    .clk              (clk),
    .reset            (reset),
    .req_val          (req_val),
    .resp_rdy         (resp_rdy),
    .sub_out64        (sub_out64),
    .counter_is_zero  (counter_is_zero),
    .req_rdy          (req_rdy),
    .resp_val         (resp_val),
    .a_en             (a_en),
    .b_en             (b_en),
    .a_mux_sel        (a_mux_sel),
    .sub_mux_sel      (sub_mux_sel),
    .cntr_mux_sel     (cntr_mux_sel),
    .sign_en          (sign_en),
    .div_sign_mux_sel (div_sign_mux_sel),
    .rem_sign_mux_sel (rem_sign_mux_sel)
  );

endmodule

`default_nettype wire

// ==== hdl/imuldiv_int_mul_iterative.sv ====
//--------------------
// iterative multiplier engine
// shift-and-add on operand magnitudes, product negated for signed ops
//--------------------

`timescale 1ns/100ps
`default_nettype none

module imuldiv_int_mul_iterative (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             is_signed,
  input  logic [imuldiv_pkg::DATA_W-1:0]   req_a,
  input  logic [imuldiv_pkg::DATA_W-1:0]   req_b,
  input  logic                             req_val,
  output logic                             req_rdy,
  output logic [imuldiv_pkg::RESULT_W-1:0] resp_result,
  output logic                             resp_val,
  input  logic                             resp_rdy
);

  localparam int W = imuldiv_pkg::DATA_W;

  imuldiv_pkg::iter_state_t state;
  logic [imuldiv_pkg::CNT_W-1:0] cnt;
  logic req_go;

  // multiplicand grows left, multiplier drains right
  logic [imuldiv_pkg::RESULT_W-1:0] mcand_reg;
  logic [W-1:0] mplier_reg;
  logic [imuldiv_pkg::RESULT_W-1:0] prod_reg;
  logic neg_reg;

  logic [W-1:0] a_mag;
  logic [W-1:0] b_mag;

  assign a_mag = (is_signed && req_a[W-1]) ? -req_a : req_a;
  assign b_mag = (is_signed && req_b[W-1]) ? -req_b : req_b;

  assign req_rdy  = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val = (state == imuldiv_pkg::ST_DONE);
  assign req_go   = req_rdy && req_val;

  //--------------------
  // FSM and counter
  //--------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        imuldiv_pkg::ST_IDLE: begin
          cnt <= imuldiv_pkg::CNT_W'(imuldiv_pkg::ITER_COUNT - 1);
          if (req_val) state <= imuldiv_pkg::ST_CALC;
        end
        imuldiv_pkg::ST_CALC: begin
          cnt <= cnt - 1'b1;
          // 32nd add happens on the zero count
          if (cnt == '0) state <= imuldiv_pkg::ST_DONE;
        end
        imuldiv_pkg::ST_DONE: begin
          // held until the response is taken
          if (resp_rdy) state <= imuldiv_pkg::ST_IDLE;
        end
        default: state <= imuldiv_pkg::ST_IDLE;
      endcase
    end
  end

  // shift-and-add datapath
  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand_reg  <= {{W{1'b0}}, a_mag};
      mplier_reg <= b_mag;
      prod_reg   <= '0;
      neg_reg    <= is_signed && (req_a[W-1] ^ req_b[W-1]);
    end else if (state == imuldiv_pkg::ST_CALC) begin
      if (mplier_reg[0]) begin
        prod_reg <= prod_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  assign resp_result = neg_reg ? -prod_reg : prod_reg;

endmodule

`default_nettype wire

// ==== hdl/imuldiv_muldiv_unit.sv ====
//--------------------
// multiply/divide unit top level
// routes requests by function, one operation outstanding at a time
//--------------------

`timescale 1ns/100ps
`default_nettype none

module imuldiv_muldiv_unit (
  input  logic                             clk,
  input  logic                             reset,
  input  imuldiv_pkg::muldiv_fn_t          req_fn,
  input  logic [imuldiv_pkg::DATA_W-1:0]   req_a,
  input  logic [imuldiv_pkg::DATA_W-1:0]   req_b,
  input  logic                             req_val,
  output logic                             req_rdy,
  output logic [imuldiv_pkg::RESULT_W-1:0] resp_result,
  output logic                             resp_val,
  input  logic                             resp_rdy
);

  //--------------------
  // function decode
  //--------------------

  logic sel_div;
  logic is_signed;
  logic busy;
  imuldiv_pkg::owner_t owner;

  assign sel_div   = (req_fn == imuldiv_pkg::FN_DIV) || (req_fn == imuldiv_pkg::FN_DIVU);
  assign is_signed = (req_fn == imuldiv_pkg::FN_MUL) || (req_fn == imuldiv_pkg::FN_DIV);
  assign busy      = (owner != imuldiv_pkg::OWN_NONE);

  // engine handshakes
  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic mul_resp_rdy;
  logic [imuldiv_pkg::RESULT_W-1:0] mul_result;
  logic div_req_val;
  logic div_req_rdy;
  logic div_resp_val;
  logic div_resp_rdy;
  logic [imuldiv_pkg::RESULT_W-1:0] div_result;

  assign mul_req_val = req_val && !busy && !sel_div;
  assign div_req_val = req_val && !busy && sel_div;
  assign req_rdy     = !busy && (sel_div ? div_req_rdy : mul_req_rdy);

  // owner set on accept, cleared when the response leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= imuldiv_pkg::OWN_NONE;
    end else if (req_val && req_rdy) begin
      owner <= sel_div ? imuldiv_pkg::OWN_DIV : imuldiv_pkg::OWN_MUL;
    end else if (resp_val && resp_rdy) begin
      owner <= imuldiv_pkg::OWN_NONE;
    end
  end

  //--------------------
  // response mux
  //--------------------

  assign mul_resp_rdy = resp_rdy && (owner == imuldiv_pkg::OWN_MUL);
  assign div_resp_rdy = resp_rdy && (owner == imuldiv_pkg::OWN_DIV);
  assign resp_val     = (owner == imuldiv_pkg::OWN_MUL) ? mul_resp_val :
                        (owner == imuldiv_pkg::OWN_DIV) ? div_resp_val : 1'b0;
  assign resp_result  = (owner == imuldiv_pkg::OWN_DIV) ? div_result : mul_result;

  imuldiv_int_mul_iterative u_mul (
    .clk         (clk),
    .reset       (reset),
    .is_signed   (is_signed),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy)
  );

  imuldiv_int_div_iterative u_div (
    .clk         (clk),
    .reset       (reset),
    .is_signed   (is_signed),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy)
  );

endmodule

`default_nettype wire

// ==== hdl/imuldiv_pkg.sv ====
//--------------------
// imuldiv shared definitions
// function codes, datapath widths and engine state encodings
//--------------------

`default_nettype none

package imuldiv_pkg;

  //--------------------
  // widths and iteration count
  //--------------------

  // operand width
  localparam int DATA_W = 32;
  // remainder/quotient or full product
  localparam int RESULT_W = 64;
  // one iteration per operand bit
  localparam int ITER_COUNT = 32;
  // counter runs ITER_COUNT-1 down to 0
  localparam int CNT_W = 5;

  //--------------------
  // request function codes
  //--------------------

  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_MULU = 2'd1,
    FN_DIV  = 2'd2,
    FN_DIVU = 2'd3
  } muldiv_fn_t;

  // engine FSM states, shared by divider control and multiplier
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } iter_state_t;

  // which engine holds the outstanding operation
  typedef enum logic [1:0] {
    OWN_NONE = 2'd0,
    OWN_MUL  = 2'd1,
    OWN_DIV  = 2'd2
  } owner_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the imuldiv testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module imuldiv_tb -f filelist.f -o imuldiv_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/imuldiv_sim > sim.log 2>&1
cat sim.log

grep -q '^>>> PASS$' sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

// ==== verification/imuldiv_assertions.sv ====
//--------------------
// imuldiv protocol checks
// latency, response hold and single outstanding op, bound into the top level
//--------------------

`timescale 1ns/100ps
`default_nettype none

module imuldiv_assertions (
  input logic                             clk,
  input logic                             reset,
  input logic                             req_val,
  input logic                             req_rdy,
  input logic [imuldiv_pkg::RESULT_W-1:0] resp_result,
  input logic                             resp_val,
  input logic                             resp_rdy
);

  // an op is in flight from its request transfer to its response transfer
  logic pending;
  // cycles since the request transfer, saturating
  logic [6:0] wait_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending  <= 1'b0;
      wait_cnt <= '0;
    end else if (req_val && req_rdy) begin
      pending  <= 1'b1;
      wait_cnt <= '0;
    end else if (resp_val && resp_rdy) begin
      pending <= 1'b0;
    end else if (pending && (wait_cnt != '1)) begin
      wait_cnt <= wait_cnt + 7'd1;
    end
  end

  //--------------------
  // properties
  //--------------------

  // no response left over once reset has been seen
  reset_idle: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high in the cycle after reset");

  // low for 32 sampled cycles after the transfer, high from the 33rd on
  resp_latency: assert property (@(posedge clk) disable iff (reset)
    pending |-> (resp_val == (wait_cnt >= 7'(imuldiv_pkg::ITER_COUNT))))
    else $error("resp_val does not follow the 33 cycle latency");

  // a stalled response keeps its value
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else $error("response changed while stalled");

  // no new request while one is outstanding
  one_outstanding: assert property (@(posedge clk) disable iff (reset)
    pending |-> !req_rdy)
    else $error("req_rdy high while an operation is outstanding");

endmodule

bind imuldiv_muldiv_unit imuldiv_assertions u_assertions (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_result (resp_result),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy)
);

`default_nettype wire

// ==== verification/imuldiv_tb.sv ====
//--------------------
// imuldiv testbench
// directed corners, then xorshift traffic with random response stalls
//--------------------

`timescale 1ns/100ps
`default_nettype none

module imuldiv_tb;

  localparam int W            = imuldiv_pkg::DATA_W;
  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_DIRECTED = 20;
  localparam int NUM_OPS      = NUM_DIRECTED + 300;
  localparam int MAX_GAP      = 3;
  localparam int MAX_STALL    = 6;
  // 33 cycles to the response, one to accept the next, plus stall and gap
  localparam int CYCLE_LIMIT  = NUM_OPS * (34 + MAX_STALL + MAX_GAP) + RESET_CYCLES;

  logic clk;
  logic reset;
  imuldiv_pkg::muldiv_fn_t req_fn;
  logic [W-1:0] req_a;
  logic [W-1:0] req_b;
  logic req_val;
  logic req_rdy;
  logic [imuldiv_pkg::RESULT_W-1:0] resp_result;
  logic resp_val;
  logic resp_rdy;

  // scoreboard in request order
  logic [imuldiv_pkg::RESULT_W-1:0] exp_q [$];
  string name_q [$];
  int checked = 0;
  int cycles = 0;
  int stall_run = 0;
  bit pass_seen = 1'b0;
  bit fail_seen = 1'b0;
  logic [31:0] stim_state = 32'd65843;
  logic [31:0] stall_state;

  //--------------------
  // directed corners
  //--------------------

  imuldiv_pkg::muldiv_fn_t dir_fn [NUM_DIRECTED] = '{
    imuldiv_pkg::FN_MULU, imuldiv_pkg::FN_MULU, imuldiv_pkg::FN_MULU, imuldiv_pkg::FN_MULU,
    imuldiv_pkg::FN_MUL, imuldiv_pkg::FN_MUL, imuldiv_pkg::FN_MUL, imuldiv_pkg::FN_MUL,
    imuldiv_pkg::FN_MUL, imuldiv_pkg::FN_MUL, imuldiv_pkg::FN_DIVU, imuldiv_pkg::FN_DIVU,
    imuldiv_pkg::FN_DIVU, imuldiv_pkg::FN_DIVU, imuldiv_pkg::FN_DIV, imuldiv_pkg::FN_DIV,
    imuldiv_pkg::FN_DIV, imuldiv_pkg::FN_DIV, imuldiv_pkg::FN_DIV, imuldiv_pkg::FN_DIV
  };
  // sign mixes, most negative squared, divide by zero, most negative by -1
  logic [W-1:0] dir_a [NUM_DIRECTED] = '{
    32'h0, 32'h1, 32'hffffffff, 32'h12345678, 32'h7, 32'hfffffff9, 32'hfffffff9,
    32'h80000000, 32'h80000000, 32'hffffffff, 32'd100, 32'hffffffff, 32'h1234, 32'h5,
    32'hfffffff9, 32'h7, 32'hfffffff9, 32'h80000000, 32'hfffffffb, 32'h5
  };
  logic [W-1:0] dir_b [NUM_DIRECTED] = '{
    32'h5, 32'hffffffff, 32'hffffffff, 32'h9abcdef0, 32'hfffffffd, 32'h3, 32'hfffffffd,
    32'h80000000, 32'h7fffffff, 32'h0, 32'h7, 32'h1, 32'h0, 32'h9,
    32'h2, 32'hfffffffe, 32'hfffffffe, 32'hffffffff, 32'h0, 32'h0
  };

  imuldiv_muldiv_unit u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // reference model, {remainder, quotient} for divides
  function automatic logic [63:0] expected_result(input imuldiv_pkg::muldiv_fn_t fn,
                                                  input logic [W-1:0] a, input logic [W-1:0] b);
    longint sa;
    longint sb;
    logic [W-1:0] q;
    logic [W-1:0] r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (fn)
      imuldiv_pkg::FN_MULU: return {32'd0, a} * {32'd0, b};
      imuldiv_pkg::FN_MUL:  return sa * sb;
      imuldiv_pkg::FN_DIVU: begin
        q = (b == '0) ? '1 : a / b;
        r = (b == '0) ? a : a % b;
      end
      default: begin
        // zero divisor: all-ones magnitude, negated only for a negative dividend
        q = (b == '0) ? (a[W-1] ? 32'd1 : '1) : 32'(sa / sb);
        r = (b == '0) ? a : 32'(sa % sb);
      end
    endcase
    return {r, q};
  endfunction

  task automatic announce_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    fail_seen = 1'b1;
  endtask

  task automatic stop_with_failure(input string why);
    announce_failure(why);
    $fatal(1, "stopped at first error");
  endtask

  // random op with some operands pushed to corners
  task automatic pick_random_op(output imuldiv_pkg::muldiv_fn_t fn, output logic [W-1:0] a,
                                output logic [W-1:0] b);
    stim_state = xorshift32(stim_state);
    fn = imuldiv_pkg::muldiv_fn_t'(stim_state[1:0]);
    stim_state = xorshift32(stim_state);
    a = stim_state;
    stim_state = xorshift32(stim_state);
    b = stim_state;
    stim_state = xorshift32(stim_state);
    case (stim_state[3:0])
      4'd0: b = '0;
      4'd1: b = b >> 24;
      4'd2: a = 32'h80000000;
      4'd3: b = '1;
      default: ;
    endcase
  endtask

  task automatic check_response();
    logic [63:0] exp;
    string name;
    assert (exp_q.size() != 0)
      else stop_with_failure("a response arrived with no request outstanding");
    exp  = exp_q.pop_front();
    name = name_q.pop_front();
    assert (resp_result === exp)
      else stop_with_failure($sformatf("ERROR %s expected %h actual %h", name, exp, resp_result));
    checked++;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      stop_with_failure($sformatf("run hung, %0d of %0d ops checked after %0d cycles",
                                  checked, NUM_OPS, cycles));
    end
  end

  //--------------------
  // request driver
  //--------------------

  initial begin
    imuldiv_pkg::muldiv_fn_t fn;
    logic [W-1:0] a;
    logic [W-1:0] b;
    int gap;
    bit accepted;
    reset   = 1'b1;
    req_fn  = imuldiv_pkg::FN_MUL;
    req_a   = '0;
    req_b   = '0;
    req_val = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b0;
    @(negedge clk);
    assert (!resp_val && req_rdy)
      else stop_with_failure("after reset resp_val is high or req_rdy is low");
    @(posedge clk);
    #(DRIVE_DELAY);
    for (int i = 0; i < NUM_OPS; i++) begin
      if (i < NUM_DIRECTED) begin
        fn  = dir_fn[i];
        a   = dir_a[i];
        b   = dir_b[i];
        gap = 0;
      end else begin
        pick_random_op(fn, a, b);
        gap = int'(stim_state[7:4]) % (MAX_GAP + 1);
      end
      req_fn   = fn;
      req_a    = a;
      req_b    = b;
      req_val  = 1'b1;
      accepted = 1'b0;
      // held until the unit takes it, sampled mid-cycle
      while (!accepted) begin
        @(negedge clk);
        accepted = req_rdy;
        assert (accepted || i != 0)
          else stop_with_failure("first request after reset was not accepted");
        @(posedge clk);
        #(DRIVE_DELAY);
      end
      exp_q.push_back(expected_result(fn, a, b));
      name_q.push_back($sformatf("%s #%0d", fn.name(), i));
      req_val = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #(DRIVE_DELAY);
      end
    end
    while (checked < NUM_OPS) @(posedge clk);
    // unit back in idle once the last response has left
    @(negedge clk);
    if (!resp_val && req_rdy) begin
      pass_seen = 1'b1;
      $display(">>> PASS");
      $finish;
    end else begin
      stop_with_failure("unit not idle after the last response transferred");
    end
  end

  // response side, random stalls of at most MAX_STALL cycles
  initial begin
    resp_rdy    = 1'b0;
    stall_state = xorshift32(stim_state);
    @(negedge reset);
    forever begin
      @(posedge clk);
      #(DRIVE_DELAY);
      stall_state = xorshift32(stall_state);
      resp_rdy  = (stall_run >= MAX_STALL) || (stall_state[1:0] != 2'b00);
      stall_run = resp_rdy ? 0 : stall_run + 1;
      @(negedge clk);
      if (resp_val && resp_rdy) begin
        check_response();
      end
    end
  end

  // an assertion or the simulator ended the run early
  final begin
    if (!pass_seen && !fail_seen) begin
      announce_failure("run stopped before all checks completed");
    end
  end

endmodule

`default_nettype wire
